//--- periph_bus_pkg.sv
// Widths are fixed at 32 bits because the shared structs depend on them; slaves decode 12-bit offsets
package periph_bus_pkg;

  // ************************************************************************
  // bus widths and slave count
  // ************************************************************************
  parameter int apb_addr_width = 32;
  parameter int apb_data_width = 32;
  parameter int nb_slave       = 3;

  // slaves only look at the low bits of the address inside their window
  parameter int reg_off_width  = 12;

  typedef struct packed {
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  typedef struct packed {
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_setup,
    arb_access
  } arb_state_e;

  typedef struct packed {
    logic [apb_addr_width-1:0] start_addr;
    logic [apb_addr_width-1:0] end_addr;
  } addr_range_t;

  // ************************************************************************
  // address map with inclusive end addresses
  // ************************************************************************
  parameter logic [apb_addr_width-1:0] gpio_start_addr     = 32'h1A10_1000;
  parameter logic [apb_addr_width-1:0] gpio_end_addr       = 32'h1A10_1FFF;
  parameter logic [apb_addr_width-1:0] soc_ctrl_start_addr = 32'h1A10_4000;
  parameter logic [apb_addr_width-1:0] soc_ctrl_end_addr   = 32'h1A10_4FFF;
  parameter logic [apb_addr_width-1:0] timer_start_addr    = 32'h1A10_B000;
  parameter logic [apb_addr_width-1:0] timer_end_addr      = 32'h1A10_BFFF;

  // register offsets inside each slave window
  parameter logic [reg_off_width-1:0] gpio_out_off    = 12'h000;
  parameter logic [reg_off_width-1:0] gpio_dir_off    = 12'h004;
  parameter logic [reg_off_width-1:0] gpio_in_off     = 12'h008;
  parameter logic [reg_off_width-1:0] timer_ctrl_off  = 12'h000;
  parameter logic [reg_off_width-1:0] timer_count_off = 12'h004;
  parameter logic [reg_off_width-1:0] timer_cmp_off   = 12'h008;
  parameter logic [reg_off_width-1:0] soc_id_off      = 12'h000;
  parameter logic [reg_off_width-1:0] soc_scratch_off = 12'h004;
  parameter logic [reg_off_width-1:0] soc_event_off   = 12'h008;

  parameter logic [apb_data_width-1:0] chip_id = 32'h5050_1A10;

endpackage

//--- apb_arbiter.sv
// Requesters must hold psel and all fields until pready; their penable is ignored and regenerated here
`timescale 1ns/1ns

module apb_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  periph_bus_pkg::apb_req_t core_req,
  output periph_bus_pkg::apb_rsp_t core_rsp,
  input  periph_bus_pkg::apb_req_t dbg_req,
  output periph_bus_pkg::apb_rsp_t dbg_rsp,
  output periph_bus_pkg::apb_req_t bus_req,
  input  periph_bus_pkg::apb_rsp_t bus_rsp
);

  periph_bus_pkg::arb_state_e state_q;
  periph_bus_pkg::arb_state_e state_d;
  logic                       owner_q;
  logic                       owner_d;
  logic                       last_q;
  logic                       last_d;
  logic                       done;
  periph_bus_pkg::apb_req_t   sel_req;

  // the transfer ends when the slave side answers in the access phase
  assign done = (state_q == periph_bus_pkg::arb_access) && bus_rsp.pready;

  always_comb begin
    state_d = state_q;
    owner_d = owner_q;
    last_d  = last_q;
    case (state_q)
      periph_bus_pkg::arb_idle: begin
        // on a tie the port that was not served last gets the bus
        if (core_req.psel && dbg_req.psel) begin
          owner_d = ~last_q;
          state_d = periph_bus_pkg::arb_setup;
        end else if (core_req.psel) begin
          owner_d = 1'b0;
          state_d = periph_bus_pkg::arb_setup;
        end else if (dbg_req.psel) begin
          owner_d = 1'b1;
          state_d = periph_bus_pkg::arb_setup;
        end
      end
      periph_bus_pkg::arb_setup: begin
        state_d = periph_bus_pkg::arb_access;
      end
      periph_bus_pkg::arb_access: begin
        if (done) begin
          last_d  = owner_q;
          state_d = periph_bus_pkg::arb_idle;
        end
      end
      default: begin
        state_d = periph_bus_pkg::arb_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q <= periph_bus_pkg::arb_idle;
      owner_q <= 1'b0;
      // port 1 counts as served last so port 0 wins the first tie
      last_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      owner_q <= owner_d;
      last_q  <= last_d;
    end
  end

  assign sel_req = owner_q ? dbg_req : core_req;

  always_comb begin
    bus_req         = sel_req;
    bus_req.psel    = (state_q != periph_bus_pkg::arb_idle);
    bus_req.penable = (state_q == periph_bus_pkg::arb_access);
  end

  // the waiting port sees pready low until its own access phase
  always_comb begin
    core_rsp = '0;
    dbg_rsp  = '0;
    if (state_q == periph_bus_pkg::arb_access) begin
      if (owner_q) begin
        dbg_rsp = bus_rsp;
      end else begin
        core_rsp = bus_rsp;
      end
    end
  end

endmodule

//--- apb_node.sv
// Address ranges are inclusive and must not overlap; if they do the lowest slave index wins
`timescale 1ns/1ns

module apb_node (
  input  periph_bus_pkg::apb_req_t    bus_req,
  output periph_bus_pkg::apb_rsp_t    bus_rsp,
  input  periph_bus_pkg::addr_range_t ranges  [periph_bus_pkg::nb_slave-1:0],
  output periph_bus_pkg::apb_req_t    slv_req [periph_bus_pkg::nb_slave-1:0],
  input  periph_bus_pkg::apb_rsp_t    slv_rsp [periph_bus_pkg::nb_slave-1:0]
);

  logic [periph_bus_pkg::nb_slave-1:0] hit;
  logic                                any_hit;
  logic                                access;
  periph_bus_pkg::apb_rsp_t            err_rsp;

  // ************************************************************************
  // range compare
  // ************************************************************************
  always_comb begin
    for (int i = 0; i < periph_bus_pkg::nb_slave; i++) begin
      hit[i] = (bus_req.paddr >= ranges[i].start_addr) &&
               (bus_req.paddr <= ranges[i].end_addr);
    end
  end

  assign any_hit = |hit;
  assign access  = bus_req.psel & bus_req.penable;

  // only the matching slave sees psel and penable
  always_comb begin
    for (int i = 0; i < periph_bus_pkg::nb_slave; i++) begin
      slv_req[i]         = bus_req;
      slv_req[i].psel    = bus_req.psel & hit[i];
      slv_req[i].penable = bus_req.penable & hit[i];
    end
  end

  // unmapped addresses are answered here with an error and zero data
  always_comb begin
    err_rsp         = '0;
    err_rsp.pready  = access;
    err_rsp.pslverr = access;
  end

  // ************************************************************************
  // response return
  // ************************************************************************
  always_comb begin
    bus_rsp = err_rsp;
    if (any_hit) begin
      // walk downwards so the lowest matching index is the one kept
      for (int i = periph_bus_pkg::nb_slave - 1; i >= 0; i--) begin
        if (hit[i]) begin
          bus_rsp = slv_rsp[i];
        end
      end
    end
  end

endmodule

//--- apb_gpio.sv
// nb_gpio must be 1 to 32; the slave never stalls and never reports an error
`timescale 1ns/1ns

module apb_gpio #(
  parameter int nb_gpio = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  periph_bus_pkg::apb_req_t req,
  output periph_bus_pkg::apb_rsp_t rsp,
  input  logic [nb_gpio-1:0]       gpio_in,
  output logic [nb_gpio-1:0]       gpio_out,
  output logic [nb_gpio-1:0]       gpio_oe
);

  logic [nb_gpio-1:0]                      out_q;
  logic [nb_gpio-1:0]                      dir_q;
  logic [nb_gpio-1:0]                      in_meta_q;
  logic [nb_gpio-1:0]                      in_q;
  logic [periph_bus_pkg::reg_off_width-1:0] offset;
  logic                                    wr_en;

  assign offset = req.paddr[periph_bus_pkg::reg_off_width-1:0];
  assign wr_en  = req.psel & req.penable & req.pwrite;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_en) begin
      if (offset == periph_bus_pkg::gpio_out_off) begin
        out_q <= req.pwdata[nb_gpio-1:0];
      end
      if (offset == periph_bus_pkg::gpio_dir_off) begin
        dir_q <= req.pwdata[nb_gpio-1:0];
      end
    end
  end

  // two flops bring the pins into the clock domain before IN sees them
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in;
    in_q      <= in_meta_q;
  end

  always_comb begin
    rsp        = '0;
    rsp.pready = req.psel & req.penable;
    case (offset)
      periph_bus_pkg::gpio_out_off: rsp.prdata[nb_gpio-1:0] = out_q;
      periph_bus_pkg::gpio_dir_off: rsp.prdata[nb_gpio-1:0] = dir_q;
      periph_bus_pkg::gpio_in_off:  rsp.prdata[nb_gpio-1:0] = in_q;
      default:                      rsp.prdata = '0;
    endcase
  end

  // pins that are inputs drive 0 on the output side
  assign gpio_out = out_q & dir_q;
  assign gpio_oe  = dir_q;

endmodule

//--- apb_timer.sv
// Counts only while CTRL bit 0 is set; with CMP at 0 the event fires on every enabled cycle
`timescale 1ns/1ns

module apb_timer (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  periph_bus_pkg::apb_req_t req,
  output periph_bus_pkg::apb_rsp_t rsp,
  output logic                     timer_event
);

  logic                                      enable_q;
  logic [periph_bus_pkg::apb_data_width-1:0] count_q;
  logic [periph_bus_pkg::apb_data_width-1:0] cmp_q;
  logic                                      event_q;
  logic                                      match;
  logic [periph_bus_pkg::reg_off_width-1:0]  offset;
  logic                                      wr_en;

  assign offset = req.paddr[periph_bus_pkg::reg_off_width-1:0];
  assign wr_en  = req.psel & req.penable & req.pwrite;

  // a match only counts while the timer runs
  assign match = enable_q && (count_q == cmp_q);

  // ************************************************************************
  // control, compare and counter registers
  // ************************************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
    end else if (wr_en) begin
      if (offset == periph_bus_pkg::timer_ctrl_off) begin
        enable_q <= req.pwdata[0];
      end
      if (offset == periph_bus_pkg::timer_cmp_off) begin
        cmp_q <= req.pwdata;
      end
    end
  end

  // a bus write to COUNT takes priority over the wrap and the increment
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (wr_en && (offset == periph_bus_pkg::timer_count_off)) begin
      count_q <= req.pwdata;
    end else if (match) begin
      count_q <= '0;
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  // the event is registered so it lasts exactly one cycle per match
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      event_q <= 1'b0;
    end else begin
      event_q <= match;
    end
  end

  assign timer_event = event_q;

  always_comb begin
    rsp        = '0;
    rsp.pready = req.psel & req.penable;
    case (offset)
      periph_bus_pkg::timer_ctrl_off:  rsp.prdata[0] = enable_q;
      periph_bus_pkg::timer_count_off: rsp.prdata = count_q;
      periph_bus_pkg::timer_cmp_off:   rsp.prdata = cmp_q;
      default:                         rsp.prdata = '0;
    endcase
  end

endmodule

//--- apb_soc_ctrl.sv
// ID is read only; the EVENT flag is sticky and a set in the same cycle beats a clear
`timescale 1ns/1ns

module apb_soc_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  periph_bus_pkg::apb_req_t req,
  output periph_bus_pkg::apb_rsp_t rsp,
  input  logic                     timer_event
);

  logic [periph_bus_pkg::apb_data_width-1:0] scratch_q;
  logic                                      event_q;
  logic [periph_bus_pkg::reg_off_width-1:0]  offset;
  logic                                      wr_en;
  logic                                      evt_clr;

  assign offset  = req.paddr[periph_bus_pkg::reg_off_width-1:0];
  assign wr_en   = req.psel & req.penable & req.pwrite;
  assign evt_clr = wr_en && (offset == periph_bus_pkg::soc_event_off) && req.pwdata[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      scratch_q <= '0;
      event_q   <= 1'b0;
    end else begin
      if (wr_en && (offset == periph_bus_pkg::soc_scratch_off)) begin
        scratch_q <= req.pwdata;
      end
      if (timer_event) begin
        event_q <= 1'b1;
      end else if (evt_clr) begin
        event_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rsp        = '0;
    rsp.pready = req.psel & req.penable;
    case (offset)
      periph_bus_pkg::soc_id_off:      rsp.prdata = periph_bus_pkg::chip_id;
      periph_bus_pkg::soc_scratch_off: rsp.prdata = scratch_q;
      periph_bus_pkg::soc_event_off:   rsp.prdata[0] = event_q;
      default:                         rsp.prdata = '0;
    endcase
  end

endmodule

//--- periph_bus_wrap.sv
// Two requesters share one APB bus; slaves have no wait states and only the node reports errors
`timescale 1ns/1ns

module periph_bus_wrap #(
  parameter int nb_gpio = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  periph_bus_pkg::apb_req_t core_req,
  output periph_bus_pkg::apb_rsp_t core_rsp,
  input  periph_bus_pkg::apb_req_t dbg_req,
  output periph_bus_pkg::apb_rsp_t dbg_rsp,
  input  logic [nb_gpio-1:0]       gpio_in,
  output logic [nb_gpio-1:0]       gpio_out,
  output logic [nb_gpio-1:0]       gpio_oe,
  output logic                     timer_event
);

  localparam int gpio_idx     = 0;
  localparam int soc_ctrl_idx = 1;
  localparam int timer_idx    = 2;

  periph_bus_pkg::apb_req_t    bus_req;
  periph_bus_pkg::apb_rsp_t    bus_rsp;
  periph_bus_pkg::addr_range_t ranges  [periph_bus_pkg::nb_slave-1:0];
  periph_bus_pkg::apb_req_t    slv_req [periph_bus_pkg::nb_slave-1:0];
  periph_bus_pkg::apb_rsp_t    slv_rsp [periph_bus_pkg::nb_slave-1:0];

  // ************************************************************************
  // memory map
  // ************************************************************************
  assign ranges[gpio_idx] = '{start_addr: periph_bus_pkg::gpio_start_addr,
                              end_addr:   periph_bus_pkg::gpio_end_addr};
  assign ranges[soc_ctrl_idx] = '{start_addr: periph_bus_pkg::soc_ctrl_start_addr,
                                  end_addr:   periph_bus_pkg::soc_ctrl_end_addr};
  assign ranges[timer_idx] = '{start_addr: periph_bus_pkg::timer_start_addr,
                               end_addr:   periph_bus_pkg::timer_end_addr};

  apb_arbiter apb_arbiter_i (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .dbg_req  (dbg_req),
    .dbg_rsp  (dbg_rsp),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp)
  );

  apb_node apb_node_i (
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .ranges  (ranges),
    .slv_req (slv_req),
    .slv_rsp (slv_rsp)
  );

  apb_gpio #(
    .nb_gpio (nb_gpio)
  ) apb_gpio_i (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .req      (slv_req[gpio_idx]),
    .rsp      (slv_rsp[gpio_idx]),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

  // the timer event also sets the sticky flag in the SoC control block
  apb_soc_ctrl apb_soc_ctrl_i (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .req         (slv_req[soc_ctrl_idx]),
    .rsp         (slv_rsp[soc_ctrl_idx]),
    .timer_event (timer_event)
  );

  apb_timer apb_timer_i (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .req         (slv_req[timer_idx]),
    .rsp         (slv_rsp[timer_idx]),
    .timer_event (timer_event)
  );

endmodule

//--- tb_clk_gen.sv
// Simulation-only clock source; starts low at time 0 and toggles every half period
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period_ns = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

endmodule

//--- tb_periph_bus.sv
// Directed tests for the package address map with nb_gpio 8; the run ends at the first error
`timescale 1ns/1ns

module tb_periph_bus;

  localparam int clk_period = 100;
  localparam int nb_gpio    = 8;
  localparam int poll_limit = 20;
  // rough cycles for reset, reset values, gpio, soc, unmapped, timer and arbitration
  localparam int test_cycles = 11 + 30 + 40 + 35 + 20 + 140 + 80;

  localparam logic [31:0] unmapped_a = 32'h1A10_0000;
  localparam logic [31:0] gpio_out_a =
    periph_bus_pkg::gpio_start_addr + periph_bus_pkg::gpio_out_off;
  localparam logic [31:0] gpio_dir_a =
    periph_bus_pkg::gpio_start_addr + periph_bus_pkg::gpio_dir_off;
  localparam logic [31:0] gpio_in_a =
    periph_bus_pkg::gpio_start_addr + periph_bus_pkg::gpio_in_off;
  localparam logic [31:0] timer_ctrl_a =
    periph_bus_pkg::timer_start_addr + periph_bus_pkg::timer_ctrl_off;
  localparam logic [31:0] timer_count_a =
    periph_bus_pkg::timer_start_addr + periph_bus_pkg::timer_count_off;
  localparam logic [31:0] timer_cmp_a =
    periph_bus_pkg::timer_start_addr + periph_bus_pkg::timer_cmp_off;
  localparam logic [31:0] soc_id_a =
    periph_bus_pkg::soc_ctrl_start_addr + periph_bus_pkg::soc_id_off;
  localparam logic [31:0] soc_scratch_a =
    periph_bus_pkg::soc_ctrl_start_addr + periph_bus_pkg::soc_scratch_off;
  localparam logic [31:0] soc_event_a =
    periph_bus_pkg::soc_ctrl_start_addr + periph_bus_pkg::soc_event_off;

  logic                     clk;
  logic                     rst_n;
  periph_bus_pkg::apb_req_t core_req;
  periph_bus_pkg::apb_rsp_t core_rsp;
  periph_bus_pkg::apb_req_t dbg_req;
  periph_bus_pkg::apb_rsp_t dbg_rsp;
  logic [nb_gpio-1:0]       gpio_in;
  logic [nb_gpio-1:0]       gpio_out;
  logic [nb_gpio-1:0]       gpio_oe;
  logic                     timer_event;
  logic                     event_prev;
  integer                   seed;
  bit                       failed;
  int                       event_pulses;
  logic [31:0]              scratch_model;
  bit                       done_order[$];

  tb_clk_gen #(
    .period_ns (clk_period)
  ) tb_clk_gen_i (
    .clk (clk)
  );

  periph_bus_wrap #(
    .nb_gpio (nb_gpio)
  ) periph_bus_wrap_i (
    .clk_i       (clk),
    .rst_n       (rst_n),
    .core_req    (core_req),
    .core_rsp    (core_rsp),
    .dbg_req     (dbg_req),
    .dbg_rsp     (dbg_rsp),
    .gpio_in     (gpio_in),
    .gpio_out    (gpio_out),
    .gpio_oe     (gpio_oe),
    .timer_event (timer_event)
  );

  // ************************************************************************
  // helpers for failure, bus driving and compares
  // ************************************************************************
  task automatic stop_with_failure(input string msg);
    failed = 1'b1;
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n    <= 1'b0;
    core_req <= '0;
    dbg_req  <= '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic drive_port(input bit port, input periph_bus_pkg::apb_req_t req);
    if (port) begin
      dbg_req <= req;
    end else begin
      core_req <= req;
    end
  endtask

  task automatic run_transfer(input bit port, input logic [31:0] addr, input logic wr,
                              input logic [31:0] wdata,
                              output periph_bus_pkg::apb_rsp_t rsp);
    periph_bus_pkg::apb_req_t req;
    int                       waited;
    req        = '0;
    req.paddr  = addr;
    req.pwdata = wdata;
    req.pwrite = wr;
    req.psel   = 1'b1;
    waited     = 0;
    @(posedge clk);
    drive_port(port, req);
    @(posedge clk);
    req.penable = 1'b1;
    drive_port(port, req);
    // the access phase is held until this port's own pready comes back
    do begin
      @(negedge clk);
      rsp = port ? dbg_rsp : core_rsp;
      waited++;
      if (waited > 40) begin
        stop_with_failure($sformatf("port %0d got no pready for address 0x%h", port, addr));
      end
    end while (!rsp.pready);
    @(posedge clk);
    drive_port(port, '0);
  endtask

  task automatic apb_write(input bit port, input logic [31:0] addr, input logic [31:0] data,
                           output periph_bus_pkg::apb_rsp_t rsp);
    run_transfer(port, addr, 1'b1, data, rsp);
  endtask

  task automatic apb_read(input bit port, input logic [31:0] addr,
                          output periph_bus_pkg::apb_rsp_t rsp);
    run_transfer(port, addr, 1'b0, '0, rsp);
  endtask

  task automatic check_rsp(input string name, input periph_bus_pkg::apb_rsp_t got,
                           input logic [periph_bus_pkg::apb_data_width-1:0] exp_data,
                           input logic exp_err);
    if (got.prdata !== exp_data) begin
      stop_with_failure($sformatf("CHECK FAILED %s prdata got 0x%h expected 0x%h",
                                  name, got.prdata, exp_data));
    end
    if (got.pslverr !== exp_err) begin
      stop_with_failure($sformatf("CHECK FAILED %s pslverr got 0x%h expected 0x%h",
                                  name, got.pslverr, exp_err));
    end
  endtask

  task automatic check_gpio(input logic [nb_gpio-1:0] exp_out, input logic [nb_gpio-1:0] exp_oe);
    @(negedge clk);
    if (gpio_out !== exp_out) begin
      stop_with_failure($sformatf("CHECK FAILED gpio_out got 0x%h expected 0x%h",
                                  gpio_out, exp_out));
    end
    if (gpio_oe !== exp_oe) begin
      stop_with_failure($sformatf("CHECK FAILED gpio_oe got 0x%h expected 0x%h",
                                  gpio_oe, exp_oe));
    end
  endtask

  task automatic check_event(input logic exp_level);
    @(negedge clk);
    if (timer_event !== exp_level) begin
      stop_with_failure($sformatf("CHECK FAILED timer_event got 0x%h expected 0x%h",
                                  timer_event, exp_level));
    end
  endtask

  task automatic read_expect(input bit port, input logic [31:0] addr,
                             input logic [31:0] exp_data, input string name);
    periph_bus_pkg::apb_rsp_t rsp;
    apb_read(port, addr, rsp);
    check_rsp(name, rsp, exp_data, 1'b0);
  endtask

  // counts rising edges of the timer event and catches pulses longer than a cycle
  always @(posedge clk) begin
    event_prev <= timer_event;
    if (!rst_n) begin
      event_pulses <= 0;
    end else if (timer_event && !event_prev) begin
      event_pulses <= event_pulses + 1;
    end else if (timer_event && event_prev) begin
      stop_with_failure("timer_event stayed high for more than one cycle");
    end
  end

  // ************************************************************************
  // directed tests
  // ************************************************************************
  task automatic test_reset_values();
    read_expect(0, gpio_out_a, '0, "gpio OUT");
    read_expect(0, gpio_dir_a, '0, "gpio DIR");
    read_expect(1, timer_ctrl_a, '0, "timer CTRL");
    read_expect(1, soc_event_a, '0, "soc EVENT");
    read_expect(0, soc_scratch_a, '0, "soc SCRATCH");
    check_gpio('0, '0);
    check_event(1'b0);
  endtask

  task automatic test_gpio();
    logic [31:0]              out_word;
    logic [31:0]              dir_word;
    logic [nb_gpio-1:0]       in_val;
    periph_bus_pkg::apb_rsp_t rsp;
    out_word = $random(seed);
    dir_word = $random(seed);
    in_val   = $random(seed);
    apb_write(0, gpio_out_a, out_word, rsp);
    apb_write(1, gpio_dir_a, dir_word, rsp);
    read_expect(1, gpio_out_a, 32'(out_word[nb_gpio-1:0]), "gpio OUT");
    read_expect(0, gpio_dir_a, 32'(dir_word[nb_gpio-1:0]), "gpio DIR");
    check_gpio(out_word[nb_gpio-1:0] & dir_word[nb_gpio-1:0], dir_word[nb_gpio-1:0]);
    @(posedge clk);
    gpio_in <= in_val;
    repeat (2) @(posedge clk);
    // upper bits of IN must read back as zero
    read_expect(0, gpio_in_a, 32'(in_val), "gpio IN");
  endtask

  task automatic test_soc_ctrl();
    periph_bus_pkg::apb_rsp_t rsp;
    read_expect(0, soc_id_a, periph_bus_pkg::chip_id, "soc ID");
    apb_write(1, soc_id_a, $random(seed), rsp);
    read_expect(1, soc_id_a, periph_bus_pkg::chip_id, "soc ID after write");
    scratch_model = $random(seed);
    apb_write(0, soc_scratch_a, scratch_model, rsp);
    read_expect(1, soc_scratch_a, scratch_model, "soc SCRATCH written by core");
    scratch_model = $random(seed);
    apb_write(1, soc_scratch_a, scratch_model, rsp);
    read_expect(0, soc_scratch_a, scratch_model, "soc SCRATCH written by debug");
  endtask

  task automatic test_unmapped();
    periph_bus_pkg::apb_rsp_t rsp;
    apb_write(0, unmapped_a, $random(seed), rsp);
    check_rsp("unmapped write", rsp, '0, 1'b1);
    apb_read(1, unmapped_a, rsp);
    check_rsp("unmapped read", rsp, '0, 1'b1);
    read_expect(0, soc_scratch_a, scratch_model, "soc SCRATCH after unmapped access");
  endtask

  task automatic test_timer();
    periph_bus_pkg::apb_rsp_t rsp;
    periph_bus_pkg::apb_rsp_t first;
    int                       polls;
    apb_write(0, timer_cmp_a, 32'd20, rsp);
    apb_write(0, timer_count_a, '0, rsp);
    apb_write(0, timer_ctrl_a, 32'd1, rsp);
    polls = 0;
    do begin
      apb_read(1, soc_event_a, rsp);
      polls++;
    end while (!rsp.prdata[0] && (polls < poll_limit));
    check_rsp("soc EVENT while timer runs", rsp, 32'd1, 1'b0);
    if (event_pulses == 0) begin
      stop_with_failure("the EVENT flag was set but timer_event never pulsed");
    end
    // stop the timer first so no new event can race the clear
    apb_write(0, timer_ctrl_a, '0, rsp);
    apb_write(1, soc_event_a, 32'd1, rsp);
    read_expect(1, soc_event_a, '0, "soc EVENT after clear");
    apb_read(0, timer_count_a, first);
    apb_read(0, timer_count_a, rsp);
    check_rsp("timer COUNT while stopped", rsp, first.prdata, 1'b0);
    check_event(1'b0);
  endtask

  task automatic test_arbitration();
    // a fresh reset makes port 0 the winner of the first tie
    apply_reset();
    done_order.delete();
    fork
      begin
        for (int i = 0; i < 4; i++) begin
          read_expect(0, soc_scratch_a, '0, "core SCRATCH under contention");
          done_order.push_back(1'b0);
        end
      end
      begin
        for (int i = 0; i < 4; i++) begin
          read_expect(1, soc_id_a, periph_bus_pkg::chip_id, "debug ID under contention");
          done_order.push_back(1'b1);
        end
      end
    join
    foreach (done_order[i]) begin
      if (done_order[i] != (i % 2)) begin
        stop_with_failure($sformatf("transfer %0d finished on port %0d out of round-robin order",
                                    i, done_order[i]));
      end
    end
    // after a lone core transfer the debug port must win the next tie
    read_expect(0, soc_scratch_a, '0, "core SCRATCH before second tie");
    done_order.delete();
    fork
      begin
        read_expect(0, soc_scratch_a, '0, "core SCRATCH in second tie");
        done_order.push_back(1'b0);
      end
      begin
        read_expect(1, soc_id_a, periph_bus_pkg::chip_id, "debug ID in second tie");
        done_order.push_back(1'b1);
      end
    join
    if (done_order[0] != 1'b1) begin
      stop_with_failure("the core port won a tie although it was served last");
    end
  endtask

  initial begin
    #(test_cycles * 4 * clk_period);
    stop_with_failure("the watchdog ran out before the tests finished");
  end

  initial begin
    seed          = 32'h9c90;
    failed        = 1'b0;
    scratch_model = '0;
    rst_n         = 1'b0;
    core_req      = '0;
    dbg_req       = '0;
    gpio_in       = '0;
    apply_reset();
    test_reset_values();
    test_gpio();
    test_soc_ctrl();
    test_unmapped();
    test_timer();
    test_arbitration();
    if (!failed) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
periph_bus_pkg.sv
apb_arbiter.sv
apb_node.sv
apb_gpio.sv
apb_timer.sv
apb_soc_ctrl.sv
periph_bus_wrap.sv
tb_clk_gen.sv
tb_periph_bus.sv

//--- Bender.yml
package:
  name: periph_bus

sources:
  - periph_bus_pkg.sv
  - apb_arbiter.sv
  - apb_node.sv
  - apb_gpio.sv
  - apb_timer.sv
  - apb_soc_ctrl.sv
  - periph_bus_wrap.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_periph_bus.sv
